// File: design/clock_pkg.sv
/* Mode and field types, time field limits, segment bus sizes
   and the seven-segment digit table */
package clock_pkg;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,	// Normal timekeeping
		MODE_SET   = 2'd1,	// Time frozen, fields editable
		MODE_ALARM = 2'd2	// Alarm shown and editable
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_e;

	localparam int TIME_W = 6;
	localparam logic [TIME_W-1:0] SEC_MAX = 6'd59;
	localparam logic [TIME_W-1:0] MIN_MAX = 6'd59;
	localparam logic [TIME_W-1:0] HOU_MAX = 6'd23;

	localparam int SEG_W      = 7;	// {a,b,c,d,e,f,g}, active high
	localparam int NUM_DIGITS = 6;

	// Patterns for digits 0 to 9
	localparam logic [SEG_W-1:0] DIGIT_SEG [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage

// File: design/tick_gen.sv
/* Clock enable generator for the second tick, display scan tick
   and button sample tick */
module tick_gen #(
	parameter int unsigned TICK_DIV   = 50_000_000,
	parameter int unsigned SCAN_DIV   = 50_000,
	parameter int unsigned SAMPLE_DIV = 500_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_sample_tick
);

	localparam int unsigned DIVS [3] = '{TICK_DIV, SCAN_DIV, SAMPLE_DIV};

	logic [2:0] tick;

	// --------------------------------------------------
	// One free-running divider per enable
	// --------------------------------------------------
	for (genvar i = 0; i < 3; i++) begin : g_div
		localparam int CW = (DIVS[i] > 1) ? $clog2(DIVS[i]) : 1;

		logic [CW-1:0] cnt;
		logic          pulse;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt   <= '0;
				pulse <= 1'b0;
			end else if (cnt == CW'(DIVS[i] - 1)) begin
				cnt   <= '0;
				pulse <= 1'b1;	// Terminal count
			end else begin
				cnt   <= cnt + 1'b1;
				pulse <= 1'b0;
			end
		end

		assign tick[i] = pulse;
	end

	assign o_sec_tick    = tick[0];
	assign o_scan_tick   = tick[1];
	assign o_sample_tick = tick[2];

endmodule

// File: design/button_sync.sv
/* Button synchronizer and press detector, one pulse per
   rising sampled level */
module button_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample_tick,
	input  logic i_btn_mode,
	input  logic i_btn_pos,
	input  logic i_btn_inc,
	input  logic i_btn_alarm,
	output logic o_press_mode,
	output logic o_press_pos,
	output logic o_press_inc,
	output logic o_press_alarm
);

	logic [3:0] btn_sync;	// {alarm, inc, pos, mode}
	logic [3:0] btn_prev;	// Level at the last sample tick
	logic [3:0] press;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_sync <= '0;
			btn_prev <= '0;
		end else begin
			btn_sync <= {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};
			if (i_sample_tick)
				btn_prev <= btn_sync;
		end
	end

	// Bounce between sample ticks never reaches the edge detect
	assign press = {4{i_sample_tick}} & btn_sync & ~btn_prev;

	assign o_press_mode  = press[0];
	assign o_press_pos   = press[1];
	assign o_press_inc   = press[2];
	assign o_press_alarm = press[3];

endmodule

// File: design/clock_ctrl.sv
/* Mode, edit position and alarm enable control, routing the
   increment press to the time or the alarm */
module clock_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_press_mode,
	input  logic             i_press_pos,
	input  logic             i_press_inc,
	input  logic             i_press_alarm,
	output clock_pkg::mode_e o_mode,
	output clock_pkg::pos_e  o_pos,
	output logic             o_alarm_en,
	output logic             o_run,
	output logic             o_time_inc,
	output logic             o_alarm_inc
);

	import clock_pkg::*;

	// --------------------------------------------------
	// State registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press_mode) begin
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SET;
				MODE_SET:   o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_pos <= POS_SEC;
		end else if (i_press_pos) begin
			case (o_pos)
				POS_SEC: o_pos <= POS_MIN;
				POS_MIN: o_pos <= POS_HOU;
				default: o_pos <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm_en <= 1'b0;
		else if (i_press_alarm)
			o_alarm_en <= ~o_alarm_en;	// Toggle
	end

	// --------------------------------------------------
	// Edit strobes, same cycle as the press
	// --------------------------------------------------
	assign o_run       = (o_mode != MODE_SET);
	assign o_time_inc  = i_press_inc && (o_mode == MODE_SET);
	assign o_alarm_inc = i_press_inc && (o_mode == MODE_ALARM);

endmodule

// File: design/time_keeper.sv
/* Running time counters, alarm registers and compare,
   and the select of the value shown on the display */
module time_keeper (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_sec_tick,
	input  logic                           i_run,
	input  clock_pkg::pos_e                i_pos,
	input  clock_pkg::mode_e               i_mode,
	input  logic                           i_time_inc,
	input  logic                           i_alarm_inc,
	input  logic                           i_alarm_en,
	output logic [clock_pkg::TIME_W-1:0]   o_hou,
	output logic [clock_pkg::TIME_W-1:0]   o_min,
	output logic [clock_pkg::TIME_W-1:0]   o_sec,
	output logic                           o_alarm
);

	import clock_pkg::*;

	logic [TIME_W-1:0] sec_q, min_q, hou_q;
	logic [TIME_W-1:0] al_sec_q, al_min_q, al_hou_q;
	logic              alarm_match;

	// Next value of a field, back to zero past its limit
	function automatic logic [TIME_W-1:0] field_inc(
		input logic [TIME_W-1:0] value,
		input logic [TIME_W-1:0] limit
	);
		return (value >= limit) ? '0 : value + 1'b1;
	endfunction

	// --------------------------------------------------
	// Time of day
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_q <= '0;
			min_q <= '0;
			hou_q <= '0;
		end else if (i_time_inc) begin
			case (i_pos)	// No carry while editing
				POS_SEC: sec_q <= field_inc(sec_q, SEC_MAX);
				POS_MIN: min_q <= field_inc(min_q, MIN_MAX);
				POS_HOU: hou_q <= field_inc(hou_q, HOU_MAX);
				default: ;
			endcase
		end else if (i_sec_tick && i_run) begin
			sec_q <= field_inc(sec_q, SEC_MAX);
			if (sec_q == SEC_MAX) begin
				min_q <= field_inc(min_q, MIN_MAX);
				if (min_q == MIN_MAX)
					hou_q <= field_inc(hou_q, HOU_MAX);	// 23 wraps to 00
			end
		end
	end

	// --------------------------------------------------
	// Alarm time and flag
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al_sec_q <= '0;
			al_min_q <= '0;
			al_hou_q <= '0;
		end else if (i_alarm_inc) begin
			case (i_pos)
				POS_SEC: al_sec_q <= field_inc(al_sec_q, SEC_MAX);
				POS_MIN: al_min_q <= field_inc(al_min_q, MIN_MAX);
				POS_HOU: al_hou_q <= field_inc(al_hou_q, HOU_MAX);
				default: ;
			endcase
		end
	end

	assign alarm_match = (sec_q == al_sec_q) && (min_q == al_min_q) && (hou_q == al_hou_q);

	// Latches on a match, drops only when disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en && (alarm_match || o_alarm);
	end

	// Display value
	always_comb begin
		if (i_mode == MODE_ALARM) begin
			o_hou = al_hou_q;
			o_min = al_min_q;
			o_sec = al_sec_q;
		end else begin
			o_hou = hou_q;
			o_min = min_q;
			o_sec = sec_q;
		end
	end

endmodule

// File: design/seg_display.sv
/* Six-digit multiplexed seven-segment driver with
   decimal point marking for edit and alarm */
module seg_display (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_scan_tick,
	input  logic [clock_pkg::TIME_W-1:0]     i_hou,
	input  logic [clock_pkg::TIME_W-1:0]     i_min,
	input  logic [clock_pkg::TIME_W-1:0]     i_sec,
	input  clock_pkg::mode_e                 i_mode,
	input  clock_pkg::pos_e                  i_pos,
	input  logic                             i_alarm,
	output logic [clock_pkg::SEG_W-1:0]      o_seg,
	output logic                             o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	import clock_pkg::*;

	localparam int SCAN_W = $clog2(NUM_DIGITS);

	logic [SCAN_W-1:0]     scan_q;
	logic [3:0]            digit [NUM_DIGITS];
	logic [NUM_DIGITS-1:0] dp_mask;

	// --------------------------------------------------
	// Digit scan
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			scan_q <= '0;
		else if (i_scan_tick)
			scan_q <= (scan_q == SCAN_W'(NUM_DIGITS - 1)) ? '0 : scan_q + 1'b1;
	end

	// Ones on even digits, tens on odd, seconds first
	always_comb begin
		digit[0] = 4'(i_sec % 10);
		digit[1] = 4'(i_sec / 10);
		digit[2] = 4'(i_min % 10);
		digit[3] = 4'(i_min / 10);
		digit[4] = 4'(i_hou % 10);
		digit[5] = 4'(i_hou / 10);
	end

	// --------------------------------------------------
	// Decimal point marks
	// --------------------------------------------------
	always_comb begin
		dp_mask = '0;
		if (i_alarm)
			dp_mask = '1;	// Ringing lights every dp
		else if (i_mode == MODE_SET)
			dp_mask[{i_pos, 1'b0}] = 1'b1;
		else if (i_mode == MODE_ALARM)
			dp_mask[{i_pos, 1'b1}] = 1'b1;
	end

	assign o_seg_enb = ~(NUM_DIGITS'(1) << scan_q);	// Active-low enable
	assign o_seg     = DIGIT_SEG[digit[scan_q]];
	assign o_seg_dp  = dp_mask[scan_q];

endmodule

// File: design/digital_clock.sv
/* Digital clock top level with tick generation, buttons,
   control, timekeeping and display */
module digital_clock #(
	parameter int unsigned TICK_DIV   = 50_000_000,
	parameter int unsigned SCAN_DIV   = 50_000,
	parameter int unsigned SAMPLE_DIV = 500_000
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_btn_mode,
	input  logic                             i_btn_pos,
	input  logic                             i_btn_inc,
	input  logic                             i_btn_alarm,
	output logic [clock_pkg::SEG_W-1:0]      o_seg,
	output logic                             o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic                             o_alarm
);

	import clock_pkg::*;

	logic              sec_tick, scan_tick, sample_tick;
	logic              press_mode, press_pos, press_inc, press_alarm;
	mode_e             mode;
	pos_e              pos;
	logic              alarm_en, run, time_inc, alarm_inc;
	logic [TIME_W-1:0] disp_hou, disp_min, disp_sec;

	tick_gen #(
		.TICK_DIV   (TICK_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) tick_gen_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.o_sec_tick    (sec_tick),
		.o_scan_tick   (scan_tick),
		.o_sample_tick (sample_tick)
	);

	button_sync button_sync_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sample_tick (sample_tick),
		.i_btn_mode    (i_btn_mode),
		.i_btn_pos     (i_btn_pos),
		.i_btn_inc     (i_btn_inc),
		.i_btn_alarm   (i_btn_alarm),
		.o_press_mode  (press_mode),
		.o_press_pos   (press_pos),
		.o_press_inc   (press_inc),
		.o_press_alarm (press_alarm)
	);

	clock_ctrl clock_ctrl_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_press_mode  (press_mode),
		.i_press_pos   (press_pos),
		.i_press_inc   (press_inc),
		.i_press_alarm (press_alarm),
		.o_mode        (mode),
		.o_pos         (pos),
		.o_alarm_en    (alarm_en),
		.o_run         (run),
		.o_time_inc    (time_inc),
		.o_alarm_inc   (alarm_inc)
	);

	time_keeper time_keeper_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_run       (run),
		.i_pos       (pos),
		.i_mode      (mode),
		.i_time_inc  (time_inc),
		.i_alarm_inc (alarm_inc),
		.i_alarm_en  (alarm_en),
		.o_hou       (disp_hou),
		.o_min       (disp_min),
		.o_sec       (disp_sec),
		.o_alarm     (o_alarm)
	);

	seg_display seg_display_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_hou       (disp_hou),
		.i_min       (disp_min),
		.i_sec       (disp_sec),
		.i_mode      (mode),
		.i_pos       (pos),
		.i_alarm     (o_alarm),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

// File: dv/tb_digital_clock.sv
/* Testbench for the digital clock with a time and alarm model,
   button presses, display scan decoding, checks and watchdog */
module tb_digital_clock;

	timeunit 1ns;
	timeprecision 1ps;

	import clock_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int TICK_DIV   = 200;
	localparam int SCAN_DIV   = 2;
	localparam int SAMPLE_DIV = 4;
	localparam int SAFE_LO    = 8;	// Tick phase window for presses and reads
	localparam int SAFE_HI    = TICK_DIV - 40;
	localparam int TICK_BUDGET  = 62;
	localparam int PRESS_BUDGET = 530;
	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;
	localparam logic [TIME_W-1:0] LIM [3] = '{SEC_MAX, MIN_MAX, HOU_MAX};

	logic                  clk;
	logic                  rst_n;
	logic [3:0]            btn;	// {alarm, inc, pos, mode}
	logic [SEG_W-1:0]      o_seg;
	logic                  o_seg_dp;
	logic [NUM_DIGITS-1:0] o_seg_enb;
	logic                  o_alarm;

	// Reference model with fields in sec, min, hou order
	logic [TIME_W-1:0] t_f [3] = '{default: '0};
	logic [TIME_W-1:0] a_f [3] = '{default: '0};
	mode_e             m_mode = MODE_CLOCK;
	pos_e              m_pos = POS_SEC;
	int                cyc = 0;
	int                ticks_run = 0;	// Seconds counted while running
	int                applied = 0;
	logic [15:0]       lfsr = 16'd22842;

	string cur_test;
	int    test_errs;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    total_errs = 0;

	digital_clock #(
		.TICK_DIV   (TICK_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) digital_clock_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn[BTN_MODE]),
		.i_btn_pos   (btn[BTN_POS]),
		.i_btn_inc   (btn[BTN_INC]),
		.i_btn_alarm (btn[BTN_ALARM]),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb),
		.o_alarm     (o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Second tick lands TICK_DIV+1 edges after reset release
	always @(posedge clk) begin
		if (rst_n) begin
			cyc <= cyc + 1;
			if ((cyc + 1) % TICK_DIV == 1 && cyc > 0 && m_mode != MODE_SET)
				ticks_run <= ticks_run + 1;
		end
	end

	// Watchdog
	initial begin
		#(2 * (TICK_BUDGET * TICK_DIV + PRESS_BUDGET * 6 * SAMPLE_DIV) * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Model helpers
	// --------------------------------------------------
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic advance_second();
		logic carry;
		carry = 1'b1;
		for (int i = 0; i < 3; i++) begin
			if (carry) begin
				if (t_f[i] == LIM[i]) begin
					t_f[i] = '0;	// Carry on
				end else begin
					t_f[i] = t_f[i] + 1'b1;
					carry = 1'b0;
				end
			end
		end
	endtask

	task automatic sync_model();
		while (applied < ticks_run) begin
			advance_second();
			applied++;
		end
	endtask

	function automatic int day_seconds(input logic [TIME_W-1:0] hh, mm, ss);
		return int'(hh) * 3600 + int'(mm) * 60 + int'(ss);
	endfunction

	function automatic logic [23:0] to_bcd(input logic [TIME_W-1:0] hh, mm, ss);
		return {4'(hh / 10), 4'(hh % 10), 4'(mm / 10), 4'(mm % 10),
			4'(ss / 10), 4'(ss % 10)};
	endfunction

	function automatic logic [3:0] decode_seg(input logic [SEG_W-1:0] seg);
		logic [3:0] val;
		val = 4'hF;	// No match
		for (int i = 0; i < 10; i++)
			if (DIGIT_SEG[i] == seg)
				val = 4'(i);
		return val;
	endfunction

	// --------------------------------------------------
	// Reporting
	// --------------------------------------------------
	task automatic begin_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("%s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", cur_test, test_errs);
		end
	endtask

	task automatic check_value(input string what, input logic [23:0] exp,
		input logic [23:0] got);
		assert (got == exp) else begin
			$display("Fail %s, %s: expected %h, actual %h", cur_test, what, exp, got);
			test_errs++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errs++;
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	task automatic wait_safe();
		while (cyc % TICK_DIV < SAFE_LO || cyc % TICK_DIV > SAFE_HI) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Model follows the press before any tick can intervene
	task automatic note_press(input int id);
		int p;
		p = int'(m_pos);
		case (id)
			BTN_MODE: begin
				case (m_mode)
					MODE_CLOCK: m_mode = MODE_SET;
					MODE_SET:   m_mode = MODE_ALARM;
					default:    m_mode = MODE_CLOCK;
				endcase
			end
			BTN_POS: begin
				case (m_pos)
					POS_SEC: m_pos = POS_MIN;
					POS_MIN: m_pos = POS_HOU;
					default: m_pos = POS_SEC;
				endcase
			end
			BTN_INC: begin
				if (m_mode == MODE_SET)
					t_f[p] = (t_f[p] == LIM[p]) ? '0 : t_f[p] + 1'b1;
				else if (m_mode == MODE_ALARM)
					a_f[p] = (a_f[p] == LIM[p]) ? '0 : a_f[p] + 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic btn_down(input int id);
		wait_safe();
		sync_model();
		note_press(id);
		btn[id] = 1'b1;
	endtask

	task automatic btn_release(input int id);
		btn[id] = 1'b0;
		repeat (3 * SAMPLE_DIV) @(posedge clk);
		#1;
	endtask

	task automatic press(input int id);
		btn_down(id);
		repeat (3 * SAMPLE_DIV) @(posedge clk);
		#1;
		btn_release(id);
	endtask

	// Edits time in SET mode or alarm in ALARM mode
	task automatic set_fields(input logic [TIME_W-1:0] hh, mm, ss);
		logic [TIME_W-1:0] target [3];
		int n;
		target[0] = ss;
		target[1] = mm;
		target[2] = hh;
		for (int p = 0; p < 3; p++) begin
			while (int'(m_pos) != p)
				press(BTN_POS);
			if (m_mode == MODE_ALARM)
				n = int'(target[p]) - int'(a_f[p]);
			else
				n = int'(target[p]) - int'(t_f[p]);
			if (n < 0)
				n = n + int'(LIM[p]) + 1;	// Wraps without a carry
			repeat (n) press(BTN_INC);
		end
	endtask

	// Catches one full scan starting at digit 0
	task automatic read_display(output logic [23:0] bcd, output logic [5:0] dp);
		logic [3:0] val;
		wait_safe();
		sync_model();
		bcd = '0;
		dp = '0;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			@(negedge clk);
			while (o_seg_enb != ~(6'b1 << d))
				@(negedge clk);
			val = decode_seg(o_seg);
			assert (val != 4'hF) else report_error("segment pattern is not a digit");
			bcd[4*d +: 4] = val;
			dp[d] = o_seg_dp;
		end
		@(posedge clk);
		#1;
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic reset_and_modes();
		logic [23:0] bcd;
		logic [5:0]  dp;
		begin_test("reset and mode cycle");
		read_display(bcd, dp);
		check_value("display after reset", 24'h000000, bcd);
		check_value("dp after reset", 24'h00, 24'(dp));
		check_value("alarm after reset", 24'h0, 24'(o_alarm));
		press(BTN_MODE);
		read_display(bcd, dp);
		check_value("dp in set mode", 24'h01, 24'(dp));	// Seconds ones
		press(BTN_MODE);
		read_display(bcd, dp);
		check_value("dp in alarm mode", 24'h02, 24'(dp));	// Seconds tens
		press(BTN_MODE);
		read_display(bcd, dp);
		check_value("dp in clock mode", 24'h00, 24'(dp));
		end_test();
	endtask

	task automatic day_rollover();
		logic [23:0] bcd;
		logic [5:0]  dp;
		int          s0;
		begin_test("set and day rollover");
		press(BTN_MODE);
		set_fields(6'd23, 6'd59, 6'd55);
		read_display(bcd, dp);
		check_value("time after set", 24'h235955, bcd);
		repeat (3 * TICK_DIV) @(posedge clk);
		#1;
		read_display(bcd, dp);
		check_value("time frozen in set", 24'h235955, bcd);
		s0 = ticks_run;
		press(BTN_MODE);	// Runs again from here
		press(BTN_MODE);
		while (ticks_run < s0 + 7) begin
			@(posedge clk);
			#1;
		end
		read_display(bcd, dp);
		check_value("time after rollover", 24'h000002, bcd);
		end_test();
	endtask

	task automatic second_edit_wrap();
		logic [23:0]       bcd;
		logic [5:0]        dp;
		logic [31:0]       v;
		logic [TIME_W-1:0] h0, m0, s0;
		int                n;
		begin_test("second edit wrap");
		press(BTN_MODE);
		press(BTN_POS);
		read_display(bcd, dp);
		check_value("dp on seconds", 24'h01, 24'(dp));
		random_bits(6, v);
		n = 40 + int'(v % 61);
		h0 = t_f[2];
		m0 = t_f[1];
		s0 = t_f[0];
		repeat (n) press(BTN_INC);
		read_display(bcd, dp);
		check_value("seconds after increments",
			to_bcd(h0, m0, 6'((int'(s0) + n) % 60)), bcd);
		press(BTN_POS);
		read_display(bcd, dp);
		check_value("dp on minutes", 24'h04, 24'(dp));
		press(BTN_POS);
		read_display(bcd, dp);
		check_value("dp on hours", 24'h10, 24'(dp));
		end_test();
	endtask

	task automatic alarm_ring();
		logic [23:0] bcd;
		logic [5:0]  dp;
		logic        early;
		int          tgt_s;
		int          ahead;
		int          k;
		begin_test("alarm ring");
		press(BTN_MODE);
		read_display(bcd, dp);
		check_value("alarm shown", to_bcd(a_f[2], a_f[1], a_f[0]), bcd);
		check_value("dp on hour tens", 24'h20, 24'(dp));
		tgt_s = (day_seconds(t_f[2], t_f[1], t_f[0]) + 40) % 86400;
		set_fields(6'(tgt_s / 3600), 6'((tgt_s / 60) % 60), 6'(tgt_s % 60));
		press(BTN_ALARM);
		press(BTN_MODE);
		check_value("alarm before match", 24'h0, 24'(o_alarm));
		sync_model();
		ahead = (tgt_s - day_seconds(t_f[2], t_f[1], t_f[0]) + 86400) % 86400;
		if (ahead <= 3) begin
			report_error("alarm time was reached before the alarm was armed");
		end else begin
			early = 1'b0;
			while (day_seconds(t_f[2], t_f[1], t_f[0]) != tgt_s) begin
				@(posedge clk);
				#1;
				if (o_alarm)
					early = 1'b1;
				sync_model();
			end
			check_value("alarm low until match", 24'h0, 24'(early));
			k = 0;
			while (!o_alarm && k < TICK_DIV) begin
				@(posedge clk);
				#1;
				k++;
			end
			check_value("alarm rise", 24'h1, 24'(o_alarm));
			read_display(bcd, dp);
			check_value("dp while ringing", 24'h3F, 24'(dp));
			check_value("time while ringing", to_bcd(t_f[2], t_f[1], t_f[0]), bcd);
		end
		end_test();
	endtask

	task automatic alarm_disable();
		logic [23:0] bcd;
		logic [5:0]  dp;
		logic        seen;
		int          pre_s;
		begin_test("alarm disable");
		repeat (3 * TICK_DIV) @(posedge clk);
		#1;
		check_value("alarm held", 24'h1, 24'(o_alarm));
		btn_down(BTN_ALARM);
		repeat (2 * SAMPLE_DIV + 1) @(posedge clk);
		#1;
		check_value("alarm after disable", 24'h0, 24'(o_alarm));
		repeat (SAMPLE_DIV) @(posedge clk);
		#1;
		btn_release(BTN_ALARM);
		// Rewind the time to just before the alarm
		pre_s = (day_seconds(a_f[2], a_f[1], a_f[0]) + 86400 - 3) % 86400;
		press(BTN_MODE);
		set_fields(6'(pre_s / 3600), 6'((pre_s / 60) % 60), 6'(pre_s % 60));
		press(BTN_MODE);
		press(BTN_MODE);
		seen = 1'b0;
		repeat (8 * TICK_DIV) begin
			@(negedge clk);
			if (o_alarm)
				seen = 1'b1;
		end
		@(posedge clk);
		#1;
		check_value("alarm on disabled match", 24'h0, 24'(seen));
		read_display(bcd, dp);
		check_value("time after second match", to_bcd(t_f[2], t_f[1], t_f[0]), bcd);
		end_test();
	endtask

	initial begin
		rst_n = 1'b0;
		btn = '0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		reset_and_modes();
		day_rollover();
		second_edit_wrap();
		alarm_ring();
		alarm_disable();
		$display("Tests run %0d, failed %0d, check errors %0d",
			tests_run, tests_failed, total_errs);
		if (tests_failed == 0 && total_errs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
design/clock_pkg.sv
design/tick_gen.sv
design/button_sync.sv
design/clock_ctrl.sv
design/time_keeper.sv
design/seg_display.sv
design/digital_clock.sv
dv/tb_digital_clock.sv

// File: Makefile
TOP := tb_digital_clock

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module digital_clock

clean:
	rm -rf obj_dir sim.log
